// ==== src/sram_pkg.sv ====
// SRAM channel package: shared widths, FIFO depth and bridge sizing

package sram_pkg;

        // ========================================
        // Datapath
        // ========================================

        // Bits carried per beat
        localparam int DATA_WIDTH = 32;

        // FIFO entries in one channel, also the full allocation space
        localparam int SRAM_DEPTH = 16;

        // Pointer address bits, pointers themselves carry one more
        localparam int ADDR_WIDTH = $clog2(SRAM_DEPTH);

        // Counts and space reports, wide enough to hold SRAM_DEPTH itself
        localparam int COUNT_WIDTH = ADDR_WIDTH + 1;

        // Burst length in beats on alloc and drain requests
        localparam int SIZE_WIDTH = 8;

        // ========================================
        // Latency bridge
        // ========================================

        // Skid entries behind the registered FIFO read
        localparam int BRIDGE_SKID_DEPTH = 4;

        // Occupancy spans 0..5: one read in flight plus a full skid queue
        localparam int BRIDGE_OCC_WIDTH = 3;

endpackage : sram_pkg

// ==== src/burst_credit_counter.sv ====
// Burst credit counter: +1 per beat pulse, -burst_size per request strobe

module burst_credit_counter #(
        // Value loaded on reset
        parameter int INIT_COUNT = 0
) (
        input  logic                             clk,
        input  logic                             rst_n,

        // Single-beat credit event
        input  logic                             beat,

        // Burst claim, one-cycle strobe with its size in beats
        input  logic                             burst_req,
        input  logic [sram_pkg::SIZE_WIDTH-1:0]  burst_size,

        output logic [sram_pkg::COUNT_WIDTH-1:0] count
);

        // Per-cycle contributions, each zero when its event is absent
        logic [sram_pkg::COUNT_WIDTH-1:0] beat_inc;
        logic [sram_pkg::COUNT_WIDTH-1:0] burst_dec;

        assign beat_inc = {{(sram_pkg::COUNT_WIDTH-1){1'b0}}, beat};

        // Burst size folded to count width; modulo arithmetic keeps the sum exact
        assign burst_dec = burst_req ? burst_size[sram_pkg::COUNT_WIDTH-1:0]
                                     : '0;

        // ========================================
        // Credit register
        // ========================================

        // Beat and burst may land on the same edge, both apply
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        count <= INIT_COUNT[sram_pkg::COUNT_WIDTH-1:0];
                end else begin
                        count <= count + beat_inc - burst_dec;
                end
        end

endmodule : burst_credit_counter

// ==== src/channel_fifo.sv ====
// Channel FIFO: synchronous storage with a registered read port like an SRAM

module channel_fifo (
        input  logic                            clk,
        input  logic                            rst_n,

        // Write port
        input  logic                            push,
        input  logic [sram_pkg::DATA_WIDTH-1:0] wr_data,

        // Read port, data valid the cycle after pop
        input  logic                            pop,
        output logic [sram_pkg::DATA_WIDTH-1:0] rd_data,

        // Status
        output logic                            full,
        output logic                            empty
);

        // ========================================
        // Storage and pointers
        // ========================================

        logic [sram_pkg::DATA_WIDTH-1:0] mem [sram_pkg::SRAM_DEPTH];

        // Extra MSB tells a full wrap apart from empty
        logic [sram_pkg::ADDR_WIDTH:0]   wr_ptr;
        logic [sram_pkg::ADDR_WIDTH:0]   rd_ptr;

        // Qualified strobes, never write a full or read an empty array
        logic                            do_push;
        logic                            do_pop;

        assign do_push = push & ~full;
        assign do_pop  = pop & ~empty;

        // Same address, MSBs differ -> writer lapped the reader
        assign full  = (wr_ptr[sram_pkg::ADDR_WIDTH] != rd_ptr[sram_pkg::ADDR_WIDTH]) &&
                       (wr_ptr[sram_pkg::ADDR_WIDTH-1:0] == rd_ptr[sram_pkg::ADDR_WIDTH-1:0]);

        // Identical pointers
        assign empty = (wr_ptr == rd_ptr);

        // ========================================
        // Pointer update
        // ========================================

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        wr_ptr <= '0;
                        rd_ptr <= '0;
                end else begin
                        if (do_push) begin
                                wr_ptr <= wr_ptr + 1'b1;
                        end
                        if (do_pop) begin
                                rd_ptr <= rd_ptr + 1'b1;
                        end
                end
        end

        // ========================================
        // Array write and registered read
        // ========================================

        always_ff @(posedge clk) begin
                if (do_push) begin
                        mem[wr_ptr[sram_pkg::ADDR_WIDTH-1:0]] <= wr_data;
                end
        end

        // Read register holds its word until the next pop
        always_ff @(posedge clk) begin
                if (do_pop) begin
                        rd_data <= mem[rd_ptr[sram_pkg::ADDR_WIDTH-1:0]];
                end
        end

endmodule : channel_fifo

// ==== src/latency_bridge.sv ====
// Latency bridge: pops the FIFO and hides its read latency behind a skid queue

module latency_bridge (
        input  logic                            clk,
        input  logic                            rst_n,

        // FIFO side
        input  logic                            fifo_empty,
        output logic                            fifo_pop,
        input  logic [sram_pkg::DATA_WIDTH-1:0] fifo_data,

        // Downstream valid/ready
        output logic                            m_valid,
        input  logic                            m_ready,
        output logic [sram_pkg::DATA_WIDTH-1:0] m_data
);

        localparam int IDX_W = $clog2(sram_pkg::BRIDGE_SKID_DEPTH);

        logic [sram_pkg::DATA_WIDTH-1:0]       skid_q [sram_pkg::BRIDGE_SKID_DEPTH];
        logic [IDX_W-1:0]                      q_wr_idx;
        logic [IDX_W-1:0]                      q_rd_idx;
        logic [sram_pkg::BRIDGE_OCC_WIDTH-1:0] q_count;

        // Beat sitting in the FIFO read register, not yet captured
        logic                                  rd_pending;
        logic [sram_pkg::BRIDGE_OCC_WIDTH-1:0] pending_ext;
        logic [sram_pkg::BRIDGE_OCC_WIDTH-1:0] occupancy;
        logic                                  m_fire;
        logic                                  capture;

        assign pending_ext = {{(sram_pkg::BRIDGE_OCC_WIDTH-1){1'b0}}, rd_pending};
        assign occupancy   = q_count + pending_ext;
        assign m_valid     = (q_count != '0);
        assign m_data      = skid_q[q_rd_idx];
        assign m_fire      = m_valid & m_ready;

        // Take the pending beat when a slot is free or the head leaves now
        assign capture  = rd_pending & ((q_count != sram_pkg::BRIDGE_SKID_DEPTH) | m_fire);

        // Below five total; a pending beat with a full queue blocks the pop
        assign fifo_pop = ~fifo_empty & (occupancy < (sram_pkg::BRIDGE_SKID_DEPTH + 1));

        // ========================================
        // Control state
        // ========================================

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        rd_pending <= 1'b0;
                        q_wr_idx   <= '0;
                        q_rd_idx   <= '0;
                        q_count    <= '0;
                end else begin
                        // New read refills the flag in the cycle the old one is captured
                        rd_pending <= fifo_pop | (rd_pending & ~capture);
                        if (capture) begin
                                q_wr_idx <= q_wr_idx + 1'b1;
                        end
                        if (m_fire) begin
                                q_rd_idx <= q_rd_idx + 1'b1;
                        end
                        case ({capture, m_fire})
                                2'b10:   q_count <= q_count + 1'b1;
                                2'b01:   q_count <= q_count - 1'b1;
                                default: q_count <= q_count;
                        endcase
                end
        end

        // Skid payload
        always_ff @(posedge clk) begin
                if (capture) begin
                        skid_q[q_wr_idx] <= fifo_data;
                end
        end

endmodule : latency_bridge

// ==== src/sram_channel_unit.sv ====
// SRAM channel unit: FIFO, latency bridge and burst credit tracking for one channel

module sram_channel_unit (
        input  logic                             clk,
        input  logic                             rst_n,

        // Allocation from the read engine
        input  logic                             axi_rd_alloc_req,
        input  logic [sram_pkg::SIZE_WIDTH-1:0]  axi_rd_alloc_size,
        output logic [sram_pkg::COUNT_WIDTH-1:0] axi_rd_alloc_space_free,

        // Beats in from the read engine
        input  logic                             axi_rd_sram_valid,
        output logic                             axi_rd_sram_ready,
        input  logic [sram_pkg::DATA_WIDTH-1:0]  axi_rd_sram_data,

        // Drain claims from the write engine
        output logic [sram_pkg::COUNT_WIDTH-1:0] axi_wr_drain_data_avail,
        input  logic                             axi_wr_drain_req,
        input  logic [sram_pkg::SIZE_WIDTH-1:0]  axi_wr_drain_size,

        // Beats out to the write engine
        output logic                             axi_wr_sram_valid,
        input  logic                             axi_wr_sram_ready,
        output logic [sram_pkg::DATA_WIDTH-1:0]  axi_wr_sram_data
);

        // Handshake pulses
        logic                             in_fire;
        logic                             out_fire;

        // FIFO to bridge
        logic                             fifo_pop;
        logic [sram_pkg::DATA_WIDTH-1:0]  fifo_rd_data;
        logic                             fifo_full;
        logic                             fifo_empty;

        // Raw allocation count, registered before it leaves
        logic [sram_pkg::COUNT_WIDTH-1:0] alloc_count;

        assign axi_rd_sram_ready = ~fifo_full;
        assign in_fire           = axi_rd_sram_valid & axi_rd_sram_ready;
        assign out_fire          = axi_wr_sram_valid & axi_wr_sram_ready;

        // ========================================
        // Credit counters
        // ========================================

        // Space comes back only when a beat leaves the unit
        burst_credit_counter #(
                .INIT_COUNT (sram_pkg::SRAM_DEPTH)
        ) u_alloc_credit (
                .clk        (clk),
                .rst_n      (rst_n),
                .beat       (out_fire),
                .burst_req  (axi_rd_alloc_req),
                .burst_size (axi_rd_alloc_size),
                .count      (alloc_count)
        );

        // Beats written minus claimed; bridge contents are already counted here
        burst_credit_counter #(
                .INIT_COUNT (0)
        ) u_drain_credit (
                .clk        (clk),
                .rst_n      (rst_n),
                .beat       (in_fire),
                .burst_req  (axi_wr_drain_req),
                .burst_size (axi_wr_drain_size),
                .count      (axi_wr_drain_data_avail)
        );

        // ========================================
        // Datapath
        // ========================================

        channel_fifo u_fifo (
                .clk     (clk),
                .rst_n   (rst_n),
                .push    (in_fire),
                .wr_data (axi_rd_sram_data),
                .pop     (fifo_pop),
                .rd_data (fifo_rd_data),
                .full    (fifo_full),
                .empty   (fifo_empty)
        );

        latency_bridge u_bridge (
                .clk        (clk),
                .rst_n      (rst_n),
                .fifo_empty (fifo_empty),
                .fifo_pop   (fifo_pop),
                .fifo_data  (fifo_rd_data),
                .m_valid    (axi_wr_sram_valid),
                .m_ready    (axi_wr_sram_ready),
                .m_data     (axi_wr_sram_data)
        );

        // Extra stage cuts the path back into the read engine
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        axi_rd_alloc_space_free <= sram_pkg::SRAM_DEPTH[sram_pkg::COUNT_WIDTH-1:0];
                end else begin
                        axi_rd_alloc_space_free <= alloc_count;
                end
        end

endmodule : sram_channel_unit

// ==== testbench/sram_channel_unit_sva.sv ====
// Flow-control assertions for the SRAM channel unit, bound to its top level

module sram_channel_unit_sva (
        input logic                             clk,
        input logic                             rst_n,
        input logic                             axi_wr_sram_valid,
        input logic                             axi_wr_sram_ready,
        input logic [sram_pkg::DATA_WIDTH-1:0]  axi_wr_sram_data,
        input logic                             axi_rd_sram_valid,
        input logic                             axi_rd_sram_ready,
        input logic                             fifo_pop,
        input logic                             fifo_empty,
        input logic [sram_pkg::COUNT_WIDTH-1:0] axi_rd_alloc_space_free
);
        timeunit 1ns;
        timeprecision 100ps;

        // Words held in the FIFO, rebuilt from its push and pop traffic
        logic [sram_pkg::COUNT_WIDTH-1:0] fifo_fill;
        logic                             in_accept;
        logic                             fifo_read;

        assign in_accept = axi_rd_sram_valid & axi_rd_sram_ready;
        assign fifo_read = fifo_pop & ~fifo_empty;

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        fifo_fill <= '0;
                end else begin
                        case ({in_accept, fifo_read})
                                2'b10:   fifo_fill <= fifo_fill + 1'b1;
                                2'b01:   fifo_fill <= fifo_fill - 1'b1;
                                default: fifo_fill <= fifo_fill;
                        endcase
                end
        end

        // Output beat holds under back-pressure
        a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
                axi_wr_sram_valid && !axi_wr_sram_ready |=>
                axi_wr_sram_valid && $stable(axi_wr_sram_data))
                else $error("output beat changed or dropped while ready was low");

        // Full FIFO takes nothing
        a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
                32'(fifo_fill) == sram_pkg::SRAM_DEPTH |-> !axi_rd_sram_ready)
                else $error("input ready high while the FIFO was full");

        // Space report bounded by the FIFO depth
        a_space_max: assert property (@(posedge clk) disable iff (!rst_n)
                32'(axi_rd_alloc_space_free) <= sram_pkg::SRAM_DEPTH)
                else $error("space free exceeds the FIFO depth");

endmodule : sram_channel_unit_sva

bind sram_channel_unit sram_channel_unit_sva u_sva (
        .clk                     (clk),
        .rst_n                   (rst_n),
        .axi_wr_sram_valid       (axi_wr_sram_valid),
        .axi_wr_sram_ready       (axi_wr_sram_ready),
        .axi_wr_sram_data        (axi_wr_sram_data),
        .axi_rd_sram_valid       (axi_rd_sram_valid),
        .axi_rd_sram_ready       (axi_rd_sram_ready),
        .fifo_pop                (fifo_pop),
        .fifo_empty              (fifo_empty),
        .axi_rd_alloc_space_free (axi_rd_alloc_space_free)
);

// ==== testbench/tb_sram_channel_unit.sv ====
// Testbench for the SRAM channel unit: table-driven bursts against a queue and counter model

module tb_sram_channel_unit;
        timeunit 1ns;
        timeprecision 100ps;

        localparam int N_TESTS = 5;
        localparam int TIMEOUT = 200;

        // Sink ready patterns
        localparam int RDY_ALWAYS = 0;
        localparam int RDY_ALT    = 1;
        localparam int RDY_HOLD   = 2;

        // Test table: burst length, alloc size, drain size, sink pattern
        localparam int BURST   [N_TESTS] = '{8, 6, 12, 21, 5};
        localparam int ALLOC   [N_TESTS] = '{8, 6, 12, 16, 5};
        localparam int DRAIN   [N_TESTS] = '{3, 8, 9, 21, 11};
        localparam int PATTERN [N_TESTS] = '{RDY_ALWAYS, RDY_ALT, RDY_ALWAYS, RDY_HOLD, RDY_ALT};

        logic                             clk;
        logic                             rst_n;
        logic                             axi_rd_alloc_req;
        logic [sram_pkg::SIZE_WIDTH-1:0]  axi_rd_alloc_size;
        logic [sram_pkg::COUNT_WIDTH-1:0] axi_rd_alloc_space_free;
        logic                             axi_rd_sram_valid;
        logic                             axi_rd_sram_ready;
        logic [sram_pkg::DATA_WIDTH-1:0]  axi_rd_sram_data;
        logic [sram_pkg::COUNT_WIDTH-1:0] axi_wr_drain_data_avail;
        logic                             axi_wr_drain_req;
        logic [sram_pkg::SIZE_WIDTH-1:0]  axi_wr_drain_size;
        logic                             axi_wr_sram_valid;
        logic                             axi_wr_sram_ready;
        logic [sram_pkg::DATA_WIDTH-1:0]  axi_wr_sram_data;

        // Reference model state
        logic [sram_pkg::DATA_WIDTH-1:0]  model_q [$];
        logic [31:0]                      rng_state;
        int                               errors;
        int                               alloc_total;
        int                               out_total;
        int                               written_total;
        int                               drained_total;
        bit                               release_sink;

        sram_channel_unit DUT (.*);

        initial begin
                clk = 1'b0;
                forever #50 clk = ~clk;
        end

        // ========================================
        // Helpers
        // ========================================

        function automatic logic [31:0] xorshift32(input logic [31:0] x);
                logic [31:0] y;
                y = x ^ (x << 13);
                y = y ^ (y >> 17);
                y = y ^ (y << 5);
                return y;
        endfunction

        task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
                if (got !== exp) begin
                        $display("MISMATCH %s: got %h, expected %h", name, got, exp);
                        errors++;
                end
        endtask

        // Step to the drive point just after the next rising edge
        task automatic wait_cycles(input int n);
                repeat (n) begin
                        @(posedge clk);
                        #5;
                end
        endtask

        task automatic pulse_alloc(input int size);
                axi_rd_alloc_req  = 1'b1;
                axi_rd_alloc_size = size[sram_pkg::SIZE_WIDTH-1:0];
                wait_cycles(1);
                axi_rd_alloc_req  = 1'b0;
        endtask

        task automatic pulse_drain(input int size);
                axi_wr_drain_req  = 1'b1;
                axi_wr_drain_size = size[sram_pkg::SIZE_WIDTH-1:0];
                wait_cycles(1);
                axi_wr_drain_req  = 1'b0;
        endtask

        // Space = 16 - allocated + beats out, avail = written - drained
        task automatic check_counters();
                int exp_space;
                int exp_avail;
                exp_space = sram_pkg::SRAM_DEPTH - alloc_total + out_total;
                exp_avail = written_total - drained_total;
                compare("axi_rd_alloc_space_free", 32'(axi_rd_alloc_space_free), 32'(exp_space));
                compare("axi_wr_drain_data_avail", 32'(axi_wr_drain_data_avail), 32'(exp_avail));
        endtask

        // ========================================
        // Source and sink
        // ========================================

        task automatic send_beats(input int n, input bit hold);
                int wait_cnt;
                for (int i = 0; i < n; i++) begin
                        rng_state         = xorshift32(rng_state);
                        axi_rd_sram_valid = 1'b1;
                        axi_rd_sram_data  = rng_state;
                        wait_cnt          = 0;
                        while (!axi_rd_sram_ready && wait_cnt < TIMEOUT) begin
                                wait_cycles(1);
                                wait_cnt++;
                        end
                        if (!axi_rd_sram_ready) begin
                                $display("Timeout: input ready stayed low at beat %0d", i);
                                errors++;
                                axi_rd_sram_valid = 1'b0;
                                return;
                        end
                        // Ready is high here, so the coming edge takes the beat
                        model_q.push_back(rng_state);
                        written_total++;
                        wait_cycles(1);
                end
                axi_rd_sram_valid = 1'b0;
                if (hold) begin
                        // Full unit: FIFO plus read in flight plus skid queue
                        compare("axi_rd_sram_ready", 32'(axi_rd_sram_ready), 32'(0));
                        release_sink = 1'b1;
                end
        endtask

        task automatic take_beats(input int n, input int pattern, input int alloc_extra);
                int  rcv;
                int  cyc;
                int  wait_cnt;
                bit  topped;
                rcv    = 0;
                cyc    = 0;
                topped = 1'b0;
                if (pattern == RDY_HOLD) begin
                        wait_cnt = 0;
                        while (!release_sink && wait_cnt < TIMEOUT) begin
                                wait_cycles(1);
                                wait_cnt++;
                        end
                        if (!release_sink) begin
                                $display("Timeout: input never stalled with the sink held off");
                                errors++;
                        end
                end
                wait_cnt = 0;
                while (rcv < n && wait_cnt < TIMEOUT) begin
                        axi_rd_alloc_req = 1'b0;
                        // Late allocation for the beats beyond the first 16
                        if (alloc_extra > 0 && !topped && rcv >= alloc_extra) begin
                                axi_rd_alloc_req  = 1'b1;
                                axi_rd_alloc_size = alloc_extra[sram_pkg::SIZE_WIDTH-1:0];
                                alloc_total      += alloc_extra;
                                topped            = 1'b1;
                        end
                        axi_wr_sram_ready = (pattern == RDY_ALT) ? cyc[0] : 1'b1;
                        if (axi_wr_sram_valid && axi_wr_sram_ready) begin
                                if (model_q.size() == 0) begin
                                        $display("Output beat appeared with nothing written");
                                        errors++;
                                end else begin
                                        compare("axi_wr_sram_data", axi_wr_sram_data,
                                                model_q.pop_front());
                                end
                                rcv++;
                                out_total++;
                                wait_cnt = 0;
                        end else begin
                                wait_cnt++;
                        end
                        wait_cycles(1);
                        cyc++;
                end
                axi_rd_alloc_req  = 1'b0;
                axi_wr_sram_ready = 1'b0;
                if (rcv < n) begin
                        $display("Timeout: output beat %0d of %0d never arrived", rcv, n);
                        errors++;
                end
        endtask

        // ========================================
        // Test sequence
        // ========================================

        initial begin
                int err_before;
                rst_n             = 1'b0;
                axi_rd_alloc_req  = 1'b0;
                axi_rd_alloc_size = '0;
                axi_rd_sram_valid = 1'b0;
                axi_rd_sram_data  = '0;
                axi_wr_drain_req  = 1'b0;
                axi_wr_drain_size = '0;
                axi_wr_sram_ready = 1'b0;
                rng_state         = 32'had81;
                errors            = 0;
                alloc_total       = 0;
                out_total         = 0;
                written_total     = 0;
                drained_total     = 0;
                release_sink      = 1'b0;
                repeat (16) @(posedge clk);
                #5 rst_n = 1'b1;
                wait_cycles(1);

                // Reset state
                check_counters();
                compare("axi_wr_sram_valid", 32'(axi_wr_sram_valid), 32'(0));
                compare("axi_rd_sram_ready", 32'(axi_rd_sram_ready), 32'(1));

                for (int t = 0; t < N_TESTS; t++) begin
                        err_before   = errors;
                        release_sink = 1'b0;
                        pulse_alloc(ALLOC[t]);
                        alloc_total += ALLOC[t];
                        wait_cycles(3);
                        check_counters();
                        fork
                                send_beats(BURST[t], PATTERN[t] == RDY_HOLD);
                                take_beats(BURST[t], PATTERN[t], BURST[t] - ALLOC[t]);
                        join
                        wait_cycles(3);
                        // Space back to full, avail counts every written beat
                        check_counters();
                        compare("axi_wr_sram_valid", 32'(axi_wr_sram_valid), 32'(0));
                        compare("axi_rd_sram_ready", 32'(axi_rd_sram_ready), 32'(1));
                        pulse_drain(DRAIN[t]);
                        drained_total += DRAIN[t];
                        wait_cycles(3);
                        check_counters();
                        $display("test %0d: %0d beats, sink %s, %0d errors", t, BURST[t],
                                 PATTERN[t] == RDY_ALWAYS ? "always" :
                                 PATTERN[t] == RDY_ALT ? "alternate" : "held off",
                                 errors - err_before);
                end

                $display("%0d tests run, %0d errors", N_TESTS, errors);
                if (errors == 0) begin
                        $display("TESTS PASSED");
                end else begin
                        $display("TESTS FAILED");
                end
                $finish;
        end

endmodule : tb_sram_channel_unit

// ==== sources.f ====
src/sram_pkg.sv
src/burst_credit_counter.sv
src/channel_fifo.sv
src/latency_bridge.sv
src/sram_channel_unit.sv
testbench/sram_channel_unit_sva.sv
testbench/tb_sram_channel_unit.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the channel testbench with Verilator, then scan the log
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/100ps \
        -f sources.f --top-module tb_sram_channel_unit > build.log 2>&1 \
        && ./obj_dir/Vtb_sram_channel_unit > sim.log 2>&1 \
        || echo "build or simulation returned an error"
cat build.log sim.log 2>/dev/null
grep -q "TESTS PASSED" sim.log && echo "run ok" || { echo "run failed"; exit 1; }
